//--- design/axis_pkg.sv
package axis_pkg;

    // stream side widths
    typedef logic [63:0] data_t;
    typedef logic [7:0]  keep_t;
    typedef logic [15:0] pkt_len_t;    // frame length and beat index
    typedef logic [31:0] frame_cnt_t;

    // no partial beats on this link
    localparam keep_t KEEP_ALL = 8'hFF;

endpackage

//--- design/pcs_pkg.sv
package pcs_pkg;

    // line block is {sync header, 64-bit payload}
    typedef logic [65:0] block_t;
    typedef logic [1:0]  sync_hdr_t;
    typedef logic [7:0]  block_type_t;
    typedef logic [57:0] scr_state_t;  // x^58 + x^39 + 1 history

    localparam sync_hdr_t SYNC_DATA = 2'b01;
    localparam sync_hdr_t SYNC_CTRL = 2'b10;

    // carried in the low byte of a control payload
    localparam block_type_t BT_IDLE  = 8'h1E;
    localparam block_type_t BT_START = 8'h78;
    localparam block_type_t BT_TERM  = 8'h87;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_term
    } tx_state_t;

    typedef enum logic {
        rx_idle,
        rx_frame
    } rx_state_t;

endpackage

//--- design/axis_if.sv
`timescale 1ns/1ps

interface axis_if;

    axis_pkg::data_t tdata;
    axis_pkg::keep_t tkeep;
    logic            tvalid;
    logic            tready;
    logic            tlast;
    logic            tuser;     // damaged frame, on the last beat only

    modport source (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

    // observe only
    modport monitor (
        input tdata, tkeep, tvalid, tready, tlast, tuser
    );

endinterface

//--- design/packet_gen.sv
`timescale 1ns/1ps

module packet_gen (
    input  logic               init_clk,
    input  logic               packet_gen_reset,
    input  logic               ctrl_reset,
    input  axis_pkg::pkt_len_t packet_length,
    input  axis_pkg::data_t    packet_data,
    output logic               core_reset,
    axis_if.source             tx
);

    logic [1:0]         reset_sync;
    axis_pkg::pkt_len_t beat_idx;
    logic               beat;

    // two flop synchronizer for the console reset
    always_ff @(posedge init_clk) begin
        if (packet_gen_reset) begin
            reset_sync <= 2'b11;    // core held until ctrl_reset seen low
        end else begin
            reset_sync <= {reset_sync[0], ctrl_reset};
        end
    end

    assign core_reset = reset_sync[1];

    assign beat = tx.tvalid && tx.tready;

    always_ff @(posedge init_clk) begin
        if (packet_gen_reset || core_reset) begin
            beat_idx <= '0;
        end else if (beat) begin
            // wrap after the last beat of the frame
            beat_idx <= (beat_idx == packet_length) ? '0 : beat_idx + 16'd1;
        end
    end

    // index in the low 16 bits, pattern above it
    assign tx.tdata  = {packet_data[63:16], beat_idx};
    assign tx.tkeep  = axis_pkg::KEEP_ALL;
    assign tx.tlast  = (beat_idx == packet_length);
    assign tx.tuser  = 1'b0;
    assign tx.tvalid = !core_reset;

    // stalled beat must not change under the encoder
    a_stall_stable: assert property (
        @(posedge init_clk) disable iff (packet_gen_reset || core_reset)
        (tx.tvalid && !tx.tready) |=>
            (tx.tvalid && $stable(tx.tdata) && $stable(tx.tlast))
    );

endmodule

//--- design/pcs_tx_encoder.sv
`timescale 1ns/1ps

module pcs_tx_encoder #(
    parameter int SCRAMBLER_BYPASS = 0
) (
    input  logic            init_clk,
    input  logic            packet_gen_reset,
    input  logic            core_reset,
    axis_if.sink            tx,
    output pcs_pkg::block_t line_block,
    output logic            line_valid
);

    pcs_pkg::tx_state_t  state;
    pcs_pkg::tx_state_t  state_next;
    pcs_pkg::sync_hdr_t  hdr;
    axis_pkg::data_t     payload;
    axis_pkg::data_t     scr_out;
    pcs_pkg::scr_state_t scr_state;
    pcs_pkg::scr_state_t scr_next;
    logic                beat;

    // control payload is just the block type in the low byte
    function automatic axis_pkg::data_t ctrl_word(input pcs_pkg::block_type_t bt);
        return {56'd0, bt};
    endfunction

    assign tx.tready = (state == pcs_pkg::tx_data);
    assign beat      = tx.tvalid && tx.tready;

    always_comb begin
        state_next = state;
        hdr        = pcs_pkg::SYNC_CTRL;
        payload    = ctrl_word(pcs_pkg::BT_IDLE);     // idle fill by default
        case (state)
            pcs_pkg::tx_idle: begin
                if (tx.tvalid) begin
                    state_next = pcs_pkg::tx_start;
                end
            end
            pcs_pkg::tx_start: begin
                payload    = ctrl_word(pcs_pkg::BT_START);
                state_next = pcs_pkg::tx_data;
            end
            pcs_pkg::tx_data: begin
                if (beat) begin
                    hdr     = pcs_pkg::SYNC_DATA;
                    payload = tx.tdata;
                    if (tx.tlast) begin
                        state_next = pcs_pkg::tx_term;
                    end
                end
            end
            pcs_pkg::tx_term: begin
                payload    = ctrl_word(pcs_pkg::BT_TERM);
                state_next = pcs_pkg::tx_idle;
            end
            default: state_next = pcs_pkg::tx_idle;
        endcase
    end

    // self-synchronizing scrambler, bit 0 goes first
    always_comb begin
        scr_next = scr_state;
        for (int i = 0; i < 64; i++) begin
            scr_out[i] = payload[i] ^ scr_next[38] ^ scr_next[57];
            scr_next   = {scr_next[56:0], scr_out[i]};
        end
    end

    always_ff @(posedge init_clk) begin
        if (packet_gen_reset || core_reset) begin
            state      <= pcs_pkg::tx_idle;
            scr_state  <= '1;
            line_valid <= 1'b0;
        end else begin
            state      <= state_next;
            scr_state  <= scr_next;
            line_valid <= 1'b1;
        end
    end

    // block register, header never scrambled
    always_ff @(posedge init_clk) begin
        line_block <= {hdr, (SCRAMBLER_BYPASS != 0) ? payload : scr_out};
    end

    // no stream beat taken while the start or terminate block goes out
    a_no_ready_ctrl: assert property (
        @(posedge init_clk) disable iff (packet_gen_reset || core_reset)
        ((state == pcs_pkg::tx_idle && tx.tvalid) || (beat && tx.tlast)) |=> !tx.tready
    );

endmodule

//--- design/pcs_rx_decoder.sv
`timescale 1ns/1ps

module pcs_rx_decoder #(
    parameter int SCRAMBLER_BYPASS = 0
) (
    input  logic            init_clk,
    input  logic            packet_gen_reset,
    input  logic            core_reset,
    input  logic            line_valid,
    input  pcs_pkg::block_t line_block,
    axis_if.source          rx
);

    pcs_pkg::scr_state_t  desc_state;
    pcs_pkg::scr_state_t  desc_next;
    axis_pkg::data_t      desc_out;
    logic                 blk_valid;
    pcs_pkg::sync_hdr_t   blk_hdr;
    axis_pkg::data_t      blk_payload;
    pcs_pkg::block_type_t blk_type;
    pcs_pkg::rx_state_t   state;
    axis_pkg::data_t      hold_data;
    logic                 hold_valid;
    logic                 frame_err;
    logic                 is_data;
    logic                 is_ctrl;
    logic                 bad_hdr;
    logic                 is_start;
    logic                 is_term;
    logic                 in_frame;
    logic                 release_beat;

    // descrambler feeds back the received bits, not its output
    always_comb begin
        desc_next = desc_state;
        for (int i = 0; i < 64; i++) begin
            desc_out[i] = line_block[i] ^ desc_next[38] ^ desc_next[57];
            desc_next   = {desc_next[56:0], line_block[i]};
        end
    end

    always_ff @(posedge init_clk) begin
        if (packet_gen_reset || core_reset) begin
            desc_state <= '1;
            blk_valid  <= 1'b0;
        end else begin
            blk_valid <= line_valid;
            if (line_valid) begin
                desc_state <= desc_next;
            end
        end
    end

    // descrambled block stage
    always_ff @(posedge init_clk) begin
        if (line_valid) begin
            blk_hdr     <= line_block[65:64];
            blk_payload <= (SCRAMBLER_BYPASS != 0) ? line_block[63:0] : desc_out;
        end
    end

    assign blk_type = blk_payload[7:0];
    assign is_data  = blk_valid && (blk_hdr == pcs_pkg::SYNC_DATA);
    assign is_ctrl  = blk_valid && (blk_hdr == pcs_pkg::SYNC_CTRL);
    assign bad_hdr  = blk_valid && !is_data && !is_ctrl;    // 00 or 11
    assign is_start = is_ctrl && (blk_type == pcs_pkg::BT_START);
    assign is_term  = is_ctrl && (blk_type == pcs_pkg::BT_TERM);
    assign in_frame = (state == pcs_pkg::rx_frame);

    // held beat goes out once the next block shows whether it was the last
    assign release_beat = in_frame && hold_valid && (is_data || bad_hdr || is_term);

    assign rx.tvalid = release_beat;
    assign rx.tdata  = hold_data;
    assign rx.tkeep  = axis_pkg::KEEP_ALL;
    assign rx.tlast  = release_beat && is_term;
    assign rx.tuser  = release_beat && is_term && frame_err;

    always_ff @(posedge init_clk) begin
        if (packet_gen_reset || core_reset) begin
            state      <= pcs_pkg::rx_idle;
            hold_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else if (!in_frame) begin
            if (is_start) begin     // anything else outside a frame is dropped
                state      <= pcs_pkg::rx_frame;
                hold_valid <= 1'b0;
                frame_err  <= 1'b0;
            end
        end else if (is_term) begin
            state      <= pcs_pkg::rx_idle;
            hold_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else if (is_data || bad_hdr) begin
            // damaged header still takes a beat slot so the length holds
            hold_valid <= 1'b1;
            if (bad_hdr) begin
                frame_err <= 1'b1;
            end
        end else if (is_ctrl) begin
            frame_err <= 1'b1;      // idle or start inside a frame
        end
    end

    always_ff @(posedge init_clk) begin
        if (in_frame && (is_data || bad_hdr)) begin
            hold_data <= blk_payload;
        end
    end

    // decoder idle again after the last beat
    a_idle_quiet: assert property (
        @(posedge init_clk) disable iff (packet_gen_reset || core_reset)
        (rx.tvalid && rx.tlast) |=> !rx.tvalid
    );

endmodule

//--- design/packet_checker.sv
`timescale 1ns/1ps

module packet_checker (
    input  logic                 init_clk,
    input  logic                 packet_gen_reset,
    input  axis_pkg::pkt_len_t   packet_length,
    input  axis_pkg::data_t      packet_data,
    axis_if.monitor              rx,
    output axis_pkg::frame_cnt_t good_frames,
    output axis_pkg::frame_cnt_t bad_frames
);

    axis_pkg::pkt_len_t exp_idx;
    axis_pkg::pkt_len_t cur_idx;
    logic               frame_err;
    logic               cur_err;
    logic               beat;
    logic               restart;
    logic               mismatch;

    assign beat = rx.tvalid && rx.tready;

    // a core reset can cut a frame short
    // a fresh index 0 mid-frame drops the partial frame uncounted
    assign restart = beat && (rx.tdata[15:0] == '0) && (exp_idx != '0);
    assign cur_idx = restart ? '0 : exp_idx;
    assign cur_err = frame_err && !restart;

    assign mismatch = (rx.tdata[15:0] != cur_idx)
                   || (rx.tdata[63:16] != packet_data[63:16])
                   || (rx.tkeep != axis_pkg::KEEP_ALL)
                   || (rx.tlast != (cur_idx == packet_length))
                   || rx.tuser;

    always_ff @(posedge init_clk) begin
        if (packet_gen_reset) begin
            exp_idx     <= '0;
            frame_err   <= 1'b0;
            good_frames <= '0;
            bad_frames  <= '0;
        end else if (beat) begin
            if (rx.tlast) begin
                exp_idx   <= '0;    // next frame starts over
                frame_err <= 1'b0;
                if (cur_err || mismatch) begin
                    bad_frames <= bad_frames + 32'd1;
                end else begin
                    good_frames <= good_frames + 32'd1;
                end
            end else begin
                exp_idx   <= cur_idx + 16'd1;
                frame_err <= cur_err || mismatch;   // sticky until tlast
            end
        end
    end

endmodule

//--- design/eth_loopback_top.sv
`timescale 1ns/1ps

module eth_loopback_top #(
    parameter int SCRAMBLER_BYPASS = 0
) (
    input  logic                 init_clk,
    input  logic                 packet_gen_reset,
    input  logic                 ctrl_reset,
    input  logic                 error_inject,
    input  axis_pkg::pkt_len_t   packet_length,
    input  axis_pkg::data_t      packet_data,
    output axis_pkg::data_t      rx_tdata,
    output axis_pkg::keep_t      rx_tkeep,
    output logic                 rx_tvalid,
    output logic                 rx_tlast,
    output logic                 rx_tuser,
    output axis_pkg::frame_cnt_t good_frames,
    output axis_pkg::frame_cnt_t bad_frames
);

    logic            core_reset;
    pcs_pkg::block_t tx_block;
    pcs_pkg::block_t rx_block;
    logic            tx_block_valid;

    axis_if tx_stream ();
    axis_if rx_stream ();

    assign rx_stream.tready = 1'b1;     // decoder has no back-pressure

    packet_gen u_packet_gen (
        .init_clk         (init_clk),
        .packet_gen_reset (packet_gen_reset),
        .ctrl_reset       (ctrl_reset),
        .packet_length    (packet_length),
        .packet_data      (packet_data),
        .core_reset       (core_reset),
        .tx               (tx_stream)
    );

    pcs_tx_encoder #(
        .SCRAMBLER_BYPASS (SCRAMBLER_BYPASS)
    ) u_pcs_tx_encoder (
        .init_clk         (init_clk),
        .packet_gen_reset (packet_gen_reset),
        .core_reset       (core_reset),
        .tx               (tx_stream),
        .line_block       (tx_block),
        .line_valid       (tx_block_valid)
    );

    // flipping header bit 64 gives 00 or 11, both invalid
    assign rx_block = {tx_block[65], tx_block[64] ^ error_inject, tx_block[63:0]};

    pcs_rx_decoder #(
        .SCRAMBLER_BYPASS (SCRAMBLER_BYPASS)
    ) u_pcs_rx_decoder (
        .init_clk         (init_clk),
        .packet_gen_reset (packet_gen_reset),
        .core_reset       (core_reset),
        .line_valid       (tx_block_valid),
        .line_block       (rx_block),
        .rx               (rx_stream)
    );

    packet_checker u_packet_checker (
        .init_clk         (init_clk),
        .packet_gen_reset (packet_gen_reset),
        .packet_length    (packet_length),
        .packet_data      (packet_data),
        .rx               (rx_stream),
        .good_frames      (good_frames),
        .bad_frames       (bad_frames)
    );

    assign rx_tdata  = rx_stream.tdata;
    assign rx_tkeep  = rx_stream.tkeep;
    assign rx_tvalid = rx_stream.tvalid;
    assign rx_tlast  = rx_stream.tlast;
    assign rx_tuser  = rx_stream.tuser;

endmodule

//--- verification/tb_eth_loopback.sv
`timescale 1ns/1ps

module tb_eth_loopback;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_LENS       = 5;
    localparam int FRAMES_PER_LEN = 4;
    localparam int INJ_FRAMES     = 7;
    localparam int CRST_FRAMES    = 6;
    localparam int CTRL_HOLD      = 6;
    localparam int NUM_RESETS     = NUM_LENS + 2;

    logic                 init_clk;
    logic                 packet_gen_reset;
    logic                 ctrl_reset;
    logic                 error_inject;
    axis_pkg::pkt_len_t   packet_length;
    axis_pkg::data_t      packet_data;
    axis_pkg::data_t      rx_tdata;
    axis_pkg::keep_t      rx_tkeep;
    logic                 rx_tvalid;
    logic                 rx_tlast;
    logic                 rx_tuser;
    axis_pkg::frame_cnt_t good_frames;
    axis_pkg::frame_cnt_t bad_frames;

    // reference model
    axis_pkg::pkt_len_t   exp_idx;
    axis_pkg::frame_cnt_t exp_good;
    axis_pkg::frame_cnt_t exp_bad;
    axis_pkg::data_t      exp_data;
    logic                 exp_last;
    logic                 exp_user;
    int                   frames_seen;
    int                   marks_used;
    int                   marked_frames;    // frames hit by an in-frame error pulse

    int                   errors;
    int                   frames_total;
    int                   watchdog_ns;
    int                   budget;
    string                test_name;
    logic [31:0]          rng;
    int                   lens[NUM_RESETS];
    axis_pkg::data_t      pats[NUM_RESETS];

    eth_loopback_top #(
        .SCRAMBLER_BYPASS (0)
    ) UUT (
        .init_clk         (init_clk),
        .packet_gen_reset (packet_gen_reset),
        .ctrl_reset       (ctrl_reset),
        .error_inject     (error_inject),
        .packet_length    (packet_length),
        .packet_data      (packet_data),
        .rx_tdata         (rx_tdata),
        .rx_tkeep         (rx_tkeep),
        .rx_tvalid        (rx_tvalid),
        .rx_tlast         (rx_tlast),
        .rx_tuser         (rx_tuser),
        .good_frames      (good_frames),
        .bad_frames       (bad_frames)
    );

    initial init_clk = 1'b0;
    always #(CLK_PERIOD / 2) init_clk = ~init_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("FAIL %s %s: expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected == actual) else report_mismatch(what, expected, actual);
    endtask

    task automatic next_cycle();
        @(posedge init_clk);
        #2;
    endtask

    // length and pattern only move while the generator is in reset
    task automatic apply_reset(input int len, input axis_pkg::data_t pat);
        packet_gen_reset = 1'b1;
        packet_length    = axis_pkg::pkt_len_t'(len);
        packet_data      = pat;
        marked_frames    = 0;
        repeat (RESET_CYCLES) next_cycle();
        packet_gen_reset = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_seen + n;
        while (frames_seen < target) next_cycle();
        frames_total += n;
    endtask

    task automatic pulse_error();
        error_inject = 1'b1;
        next_cycle();
        error_inject = 1'b0;
    endtask

    // rx beat 0 on the output means data block 2 is on the line
    task automatic inject_in_frame();
        while (!(rx_tvalid && rx_tdata[15:0] == 16'd0 && !rx_tlast)) next_cycle();
        marked_frames++;
        pulse_error();
    endtask

    // last beat out, idle block on the line
    task automatic inject_between_frames();
        while (!(rx_tvalid && rx_tlast)) next_cycle();
        pulse_error();
    endtask

    assign exp_data = {packet_data[63:16], exp_idx};
    assign exp_last = (exp_idx == packet_length);
    assign exp_user = exp_last && (marked_frames > marks_used);

    always @(posedge init_clk) begin
        if (packet_gen_reset) begin
            exp_idx     <= '0;
            exp_good    <= '0;
            exp_bad     <= '0;
            frames_seen <= 0;
            marks_used  <= 0;
        end else if (rx_tvalid) begin
            if (exp_last) begin
                exp_idx     <= '0;
                frames_seen <= frames_seen + 1;
                if (exp_user) begin
                    exp_bad    <= exp_bad + 32'd1;
                    marks_used <= marks_used + 1;
                end else begin
                    exp_good <= exp_good + 32'd1;
                end
            end else begin
                exp_idx <= exp_idx + 16'd1;
            end
        end else if (ctrl_reset) begin
            exp_idx <= '0;      // cut frame never completes
        end
    end

    a_rx_data: assert property (@(posedge init_clk) disable iff (packet_gen_reset)
        rx_tvalid |-> (rx_tdata == exp_data))
        else report_mismatch("rx data", $sampled(exp_data), $sampled(rx_tdata));

    a_rx_keep: assert property (@(posedge init_clk) disable iff (packet_gen_reset)
        rx_tvalid |-> (rx_tkeep == 8'hFF))
        else report_mismatch("rx tkeep", 64'hFF, 64'($sampled(rx_tkeep)));

    a_rx_last: assert property (@(posedge init_clk) disable iff (packet_gen_reset)
        rx_tvalid |-> (rx_tlast == exp_last))
        else report_mismatch("rx tlast", 64'($sampled(exp_last)), 64'($sampled(rx_tlast)));

    a_rx_user: assert property (@(posedge init_clk) disable iff (packet_gen_reset)
        rx_tvalid |-> (rx_tuser == exp_user))
        else report_mismatch("rx tuser", 64'($sampled(exp_user)), 64'($sampled(rx_tuser)));

    // good count in the upper word, bad count in the lower
    a_counts: assert property (@(posedge init_clk) disable iff (packet_gen_reset)
        (good_frames == exp_good) && (bad_frames == exp_bad))
        else report_mismatch("frame counters", {$sampled(exp_good), $sampled(exp_bad)},
                             {$sampled(good_frames), $sampled(bad_frames)});

    a_reset_quiet: assert property (@(posedge init_clk)
        packet_gen_reset |=> (!rx_tvalid && !rx_tuser && good_frames == '0 && bad_frames == '0))
        else report_problem("outputs not cleared by packet_gen_reset");

    a_core_stop: assert property (@(posedge init_clk) disable iff (packet_gen_reset)
        (ctrl_reset && $past(ctrl_reset) && $past(ctrl_reset, 2) && $past(ctrl_reset, 3))
            |-> !rx_tvalid)
        else report_problem("rx_tvalid still high three cycles into ctrl_reset");

    initial begin : watchdog
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("timeout: frames stopped arriving before the test sequence ended");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        int i;
        packet_gen_reset = 1'b1;
        ctrl_reset       = 1'b0;
        error_inject     = 1'b0;
        packet_length    = '0;
        packet_data      = '0;
        errors           = 0;
        frames_total     = 0;
        marked_frames    = 0;
        watchdog_ns      = 0;
        test_name        = "startup";
        rng              = 32'd35992;
        for (i = 0; i < NUM_RESETS; i++) begin
            rng           = xorshift32(rng);
            lens[i]       = int'(rng[3:0]);
            rng           = xorshift32(rng);
            pats[i][63:32] = rng;
            rng           = xorshift32(rng);
            pats[i][31:0] = rng;
        end
        lens[1]            = 0;                                 // single-beat frames
        lens[NUM_LENS]     = 2 + (lens[NUM_LENS] % 14);         // needs a data block 2
        lens[NUM_LENS + 1] = 1 + (lens[NUM_LENS + 1] % 15);     // room to cut mid-frame
        budget = 0;
        for (i = 0; i < NUM_LENS; i++) begin
            budget += FRAMES_PER_LEN * (lens[i] + 5);
        end
        budget += INJ_FRAMES * (lens[NUM_LENS] + 5) + CRST_FRAMES * (lens[NUM_LENS + 1] + 5);
        watchdog_ns = (2 * budget + NUM_RESETS * RESET_CYCLES + CTRL_HOLD) * CLK_PERIOD;

        test_name = "length_change";
        for (i = 0; i < NUM_LENS; i++) begin
            apply_reset(lens[i], pats[i]);
            wait_frames(FRAMES_PER_LEN);
            check_value("good frames", 64'(FRAMES_PER_LEN), 64'(good_frames));
            check_value("bad frames", 64'd0, 64'(bad_frames));
        end

        test_name = "error_inject";
        apply_reset(lens[NUM_LENS], pats[NUM_LENS]);
        wait_frames(1);
        inject_in_frame();
        wait_frames(2);             // damaged frame, then a clean one
        inject_between_frames();
        wait_frames(2);
        check_value("bad frames", 64'd1, 64'(bad_frames));
        check_value("good frames", 64'(frames_seen - 1), 64'(good_frames));

        test_name = "core_reset";
        apply_reset(lens[NUM_LENS + 1], pats[NUM_LENS + 1]);
        wait_frames(2);
        while (!(rx_tvalid && !rx_tlast)) next_cycle();
        ctrl_reset = 1'b1;
        repeat (CTRL_HOLD) next_cycle();
        assert (!rx_tvalid) else report_problem("rx_tvalid still high while ctrl_reset is held");
        ctrl_reset = 1'b0;
        wait_frames(3);
        check_value("bad frames", 64'd0, 64'(bad_frames));
        check_value("good frames", 64'(frames_seen), 64'(good_frames));

        $display("summary: %0d frames received, %0d errors", frames_total, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- compile.f
design/axis_pkg.sv
design/pcs_pkg.sv
design/axis_if.sv
design/packet_gen.sv
design/pcs_tx_encoder.sv
design/pcs_rx_decoder.sv
design/packet_checker.sv
design/eth_loopback_top.sv
verification/tb_eth_loopback.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_eth_loopback -Mdir obj_dir -f compile.f

output=$(./obj_dir/Vtb_eth_loopback)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'PASS: all tests'; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
